//--- beat_dispatcher.sv
module beat_dispatcher (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  cnn_pkg::act_vec_t     in_act,
    input  cnn_pkg::weight_bank_t in_weight,
    input  logic                  in_last,
    input  logic                  release_tile,
    pe_feed_if.source             feed
);
    import cnn_pkg::*;

    logic [CREDIT_W-1:0] credits;
    logic                accept;
    logic                take_credit;

    ////////////////////////////////////////
    // Credit accounting
    ////////////////////////////////////////

    // One credit per tile slot in the collector FIFO
    assign accept      = in_valid && in_ready;
    assign take_credit = accept && in_last;
    assign in_ready    = (credits != '0);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            credits <= CREDIT_W'(TILE_FIFO_DEPTH);
        end
        else if (take_credit && !release_tile)
        begin
            credits <= credits - 1'b1;
        end
        else if (release_tile && !take_credit)
        begin
            credits <= credits + 1'b1;
        end
    end

    ////////////////////////////////////////
    // Feed register
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            feed.feed_valid <= 1'b0;
        end
        else
        begin
            // Drops back low in any cycle without a transfer
            feed.feed_valid <= accept;
        end
    end

    // Beat payload, only meaningful while feed_valid is high
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            feed.act         <= in_act;
            feed.weight_bank <= in_weight;
            feed.last        <= in_last;
        end
    end

endmodule

//--- cnn_pkg.sv
package cnn_pkg;

    ////////////////////////////////////////
    // Array geometry
    ////////////////////////////////////////

    localparam int LANES           = 8;
    localparam int N_PE            = 4;
    localparam int TILE_FIFO_DEPTH = 4;

    ////////////////////////////////////////
    // Datapath widths
    ////////////////////////////////////////

    localparam int ACT_W  = 8;
    localparam int WGT_W  = 4;
    localparam int PROD_W = ACT_W + WGT_W;
    // Eight products need three extra bits
    localparam int PSUM_W = PROD_W + $clog2(LANES);
    localparam int ACC_W  = 21;

    // Counter and pointer widths
    localparam int CREDIT_W   = $clog2(TILE_FIFO_DEPTH + 1);
    localparam int FIFO_PTR_W = $clog2(TILE_FIFO_DEPTH);
    localparam int PE_IDX_W   = $clog2(N_PE);

    // Scalar lanes
    typedef logic signed [ACT_W-1:0]  act_t;
    typedef logic signed [WGT_W-1:0]  weight_t;
    typedef logic signed [PROD_W-1:0] prod_t;

    // Packed beats, lane 0 in the low bits
    typedef logic [LANES*ACT_W-1:0]      act_vec_t;
    typedef logic [LANES*WGT_W-1:0]      weight_vec_t;
    typedef logic [N_PE*LANES*WGT_W-1:0] weight_bank_t;

    // Sums
    typedef logic signed [PSUM_W-1:0] psum_t;
    typedef logic signed [ACC_W-1:0]  acc_t;
    typedef logic [PE_IDX_W-1:0]      pe_idx_t;

    // Collector output FSM
    typedef enum logic {
        COLLECT_IDLE,
        COLLECT_SEND
    } collect_state_t;

endpackage

//--- compile.f
cnn_pkg.sv
pe_feed_if.sv
beat_dispatcher.sv
mult_sum.sv
result_collector.sv
dot_engine_top.sv
dot_engine_checker.sv
tb_dot_engine.sv

//--- dot_engine_checker.sv
module dot_engine_checker (
    input logic             clk,
    input logic             rst_n,
    input logic             in_valid,
    input logic             in_ready,
    input logic             in_last,
    input logic             out_valid,
    input logic             out_ready,
    input cnn_pkg::acc_t    out_sum,
    input cnn_pkg::pe_idx_t out_index
);
    timeunit 1ns;
    timeprecision 1ps;

    // Failed assertions so far, watched by the testbench
    int error_count = 0;

    ////////////////////////////////////////
    // Output protocol
    ////////////////////////////////////////

    reset_quiet: assert property (@(posedge clk) !rst_n |-> !out_valid)
    else
    begin
        $error("out_valid high while rst_n is asserted");
        error_count++;
    end

    // Sum and index frozen while the sink stalls
    hold_stalled: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_sum) && $stable(out_index))
    else
    begin
        $error("output changed or dropped while out_ready was low");
        error_count++;
    end

    ////////////////////////////////////////
    // Latency
    ////////////////////////////////////////

    // Dispatch, product, accumulate, FIFO write
    last_latency: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid && in_ready && in_last && !out_valid |-> ##4 out_valid)
    else
    begin
        $error("out_valid missing 4 cycles after an accepted last beat");
        error_count++;
    end

endmodule

bind dot_engine_top dot_engine_checker i_dot_engine_checker (.*);

//--- dot_engine_top.sv
module dot_engine_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  cnn_pkg::act_vec_t     in_act,
    input  cnn_pkg::weight_bank_t in_weight,
    input  logic                  in_last,
    output logic                  out_valid,
    input  logic                  out_ready,
    output cnn_pkg::acc_t         out_sum,
    output cnn_pkg::pe_idx_t      out_index
);
    import cnn_pkg::*;

    pe_feed_if       feed_bus ();
    logic [N_PE-1:0] pe_done;
    acc_t            pe_acc [N_PE];
    logic            release_tile;

    ////////////////////////////////////////
    // Input side
    ////////////////////////////////////////

    beat_dispatcher i_beat_dispatcher (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .in_act       (in_act),
        .in_weight    (in_weight),
        .in_last      (in_last),
        .release_tile (release_tile),
        .feed         (feed_bus)
    );

    ////////////////////////////////////////
    // Processing elements
    ////////////////////////////////////////

    // Each PE takes its own word of the registered weight bank
    for (genvar i = 0; i < N_PE; i++)
    begin : g_pe
        mult_sum i_mult_sum (
            .clk    (clk),
            .rst_n  (rst_n),
            .feed   (feed_bus),
            .weight (feed_bus.weight_bank[i*LANES*WGT_W +: LANES*WGT_W]),
            .done   (pe_done[i]),
            .acc    (pe_acc[i])
        );
    end

    ////////////////////////////////////////
    // Output side
    ////////////////////////////////////////

    // All PEs run in lockstep, so PE 0 speaks for the tile
    result_collector i_result_collector (
        .clk          (clk),
        .rst_n        (rst_n),
        .done         (pe_done[0]),
        .pe_acc       (pe_acc),
        .release_tile (release_tile),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_sum      (out_sum),
        .out_index    (out_index)
    );

endmodule

//--- mult_sum.sv
module mult_sum (
    input  logic                 clk,
    input  logic                 rst_n,
    pe_feed_if.sink              feed,
    input  cnn_pkg::weight_vec_t weight,
    output logic                 done,
    output cnn_pkg::acc_t        acc
);
    import cnn_pkg::*;

    act_t                     act_lane    [LANES];
    weight_t                  weight_lane [LANES];
    prod_t                    prod_q      [LANES];
    logic signed [PROD_W:0]   sum_l1      [LANES/2];
    logic signed [PROD_W+1:0] sum_l2      [LANES/4];
    psum_t                    beat_sum;
    acc_t                     beat_ext;
    logic                     beat_q;
    logic                     last_q;
    logic                     tile_start;

    // Signed lanes out of the packed beat
    always_comb
    begin
        for (int i = 0; i < LANES; i++)
        begin
            act_lane[i]    = feed.act[i*ACT_W +: ACT_W];
            weight_lane[i] = weight[i*WGT_W +: WGT_W];
        end
    end

    ////////////////////////////////////////
    // Stage 1, lane products
    ////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (feed.feed_valid)
        begin
            for (int i = 0; i < LANES; i++)
            begin
                prod_q[i] <= act_lane[i] * weight_lane[i];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            beat_q <= 1'b0;
            last_q <= 1'b0;
        end
        else
        begin
            beat_q <= feed.feed_valid;
            last_q <= feed.feed_valid && feed.last;
        end
    end

    // Balanced tree, each level one bit wider
    always_comb
    begin
        for (int i = 0; i < LANES/2; i++)
        begin
            sum_l1[i] = prod_q[2*i] + prod_q[2*i+1];
        end
        for (int i = 0; i < LANES/4; i++)
        begin
            sum_l2[i] = sum_l1[2*i] + sum_l1[2*i+1];
        end
        beat_sum = sum_l2[0] + sum_l2[1];
    end

    assign beat_ext = beat_sum;

    ////////////////////////////////////////
    // Stage 2, tile accumulator
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            tile_start <= 1'b1;
            done       <= 1'b0;
        end
        else
        begin
            // done lines up with the final sum on acc
            done <= beat_q && last_q;
            if (beat_q)
            begin
                tile_start <= last_q;
            end
        end
    end

    // Wraps modulo 2**ACC_W
    always_ff @(posedge clk)
    begin
        if (beat_q)
        begin
            acc <= (tile_start ? '0 : acc) + beat_ext;
        end
    end

endmodule

//--- pe_feed_if.sv
interface pe_feed_if;
    import cnn_pkg::*;

    // One registered beat, broadcast to every PE
    logic         feed_valid;
    act_vec_t     act;
    weight_bank_t weight_bank;
    logic         last;

    // Dispatcher side
    modport source (
        output feed_valid,
        output act,
        output weight_bank,
        output last
    );

    // PE side, no ready since a PE never stalls
    modport sink (
        input feed_valid,
        input act,
        input weight_bank,
        input last
    );

endinterface

//--- result_collector.sv
module result_collector (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              done,
    input  cnn_pkg::acc_t     pe_acc [cnn_pkg::N_PE],
    output logic              release_tile,
    output logic              out_valid,
    input  logic              out_ready,
    output cnn_pkg::acc_t     out_sum,
    output cnn_pkg::pe_idx_t  out_index
);
    import cnn_pkg::*;

    acc_t                  fifo_mem [TILE_FIFO_DEPTH][N_PE];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    // Same range as the credit counter
    logic [CREDIT_W-1:0]   fill;
    collect_state_t        state;
    collect_state_t        state_nxt;
    pe_idx_t               send_idx;
    logic                  push;
    logic                  take;
    logic                  pop;

    assign push = done;
    assign take = out_valid && out_ready;
    assign pop  = take && (send_idx == PE_IDX_W'(N_PE - 1));

    ////////////////////////////////////////
    // Tile FIFO
    ////////////////////////////////////////

    // One entry holds all neuron sums of a tile
    always_ff @(posedge clk)
    begin
        if (push)
        begin
            for (int i = 0; i < N_PE; i++)
            begin
                fifo_mem[wr_ptr][i] <= pe_acc[i];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end
        else
        begin
            if (push)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push && !pop)
            begin
                fill <= fill + 1'b1;
            end
            else if (pop && !push)
            begin
                fill <= fill - 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // Output FSM
    ////////////////////////////////////////

    always_comb
    begin
        state_nxt = state;
        case (state)
            COLLECT_IDLE:
            begin
                // FIFO is always empty here
                if (push)
                begin
                    state_nxt = COLLECT_SEND;
                end
            end
            COLLECT_SEND:
            begin
                if (pop && !push && fill == CREDIT_W'(1))
                begin
                    state_nxt = COLLECT_IDLE;
                end
            end
            default:
            begin
                state_nxt = COLLECT_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state        <= COLLECT_IDLE;
            send_idx     <= '0;
            release_tile <= 1'b0;
        end
        else
        begin
            state        <= state_nxt;
            release_tile <= pop;
            if (pop)
            begin
                send_idx <= '0;
            end
            else if (take)
            begin
                send_idx <= send_idx + 1'b1;
            end
        end
    end

    // Head entry and index only move on a transfer
    assign out_valid = (state == COLLECT_SEND);
    assign out_sum   = fifo_mem[rd_ptr][send_idx];
    assign out_index = send_idx;

endmodule

//--- tb_dot_engine.sv
module tb_dot_engine;
    timeunit 1ns;
    timeprecision 1ps;
    import cnn_pkg::*;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 8;
    localparam logic [31:0] SEED = 32'he13d_7462;
    // Tiles over all tests, and beats of the long extreme tiles
    localparam int N_TILES     = 37;
    localparam int LONG_BEATS  = 400;
    localparam int WATCHDOG_NS = (RESET_CYCLES + 40 * N_TILES + LONG_BEATS) * CLK_PERIOD;

    logic         clk;
    logic         rst_n;
    logic         in_valid;
    logic         in_ready;
    act_vec_t     in_act;
    weight_bank_t in_weight;
    logic         in_last;
    logic         out_valid;
    logic         out_ready;
    acc_t         out_sum;
    pe_idx_t      out_index;

    logic [31:0] stim_state   = SEED;
    logic [31:0] ready_state  = SEED ^ 32'h5a5a_5a5a;
    logic        ready_level  = 1'b1;
    logic        ready_random = 1'b0;
    acc_t        expected [$];
    int          out_count    = 0;
    string       test_name    = "reset";

    dot_engine_top i_dot_engine_top (.*);

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic logic [31:0] next_rand();
        stim_state = xorshift(stim_state);
        return stim_state;
    endfunction

    // Reference rule: sign-extended weight times activation, summed over lanes
    function automatic int lane_dot(input act_vec_t a, input weight_vec_t w);
        int s;
        s = 0;
        for (int i = 0; i < LANES; i++)
        begin
            s += int'($signed(a[i*8 +: 8])) * int'($signed(w[i*4 +: 4]));
        end
        return s;
    endfunction

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("test failed");
        $fatal(1, "run stopped at %0t", $time);
    endtask

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    // Called 1 ns after an edge, returns 1 ns after the accepting edge
    task automatic push_beat(input act_vec_t a, input weight_bank_t w, input logic last);
        logic taken;
        in_valid  = 1'b1;
        in_act    = a;
        in_weight = w;
        in_last   = last;
        taken     = 1'b0;
        while (!taken)
        begin
            taken = in_ready;
            @(posedge clk);
            #1;
        end
        in_valid = 1'b0;
        in_last  = 1'b0;
    endtask

    // kind 0 random, 1 and 2 the extreme corners
    task automatic send_tile(input int n_beats, input int kind);
        act_vec_t     a;
        weight_bank_t w;
        int           sums [N_PE];
        for (int p = 0; p < N_PE; p++)
        begin
            sums[p] = 0;
        end
        for (int b = 0; b < n_beats; b++)
        begin
            if (kind == 0)
            begin
                a[31:0]  = next_rand();
                a[63:32] = next_rand();
                for (int q = 0; q < 4; q++)
                begin
                    w[q*32 +: 32] = next_rand();
                end
            end
            else
            begin
                a = {LANES{(kind == 1) ? 8'h80 : 8'h7f}};
                w = {N_PE * LANES{4'h8}};
            end
            for (int p = 0; p < N_PE; p++)
            begin
                sums[p] += lane_dot(a, w[p*32 +: 32]);
            end
            push_beat(a, w, b == n_beats - 1);
        end
        // Truncation gives the modulo 2**21 wrap
        for (int p = 0; p < N_PE; p++)
        begin
            expected.push_back(acc_t'(sums[p]));
        end
    endtask

    task automatic wait_drain();
        while (expected.size() != 0)
        begin
            @(posedge clk);
            #1;
        end
    endtask

    // Only driver of out_ready
    initial
    begin
        out_ready = 1'b1;
        forever
        begin
            @(posedge clk);
            #1;
            if (ready_random)
            begin
                ready_state = xorshift(ready_state);
                out_ready   = ready_state[3];
            end
            else
            begin
                out_ready = ready_level;
            end
        end
    end

    ////////////////////////////////////////
    // Scoreboard
    ////////////////////////////////////////

    always @(negedge clk)
    begin
        acc_t    exp_sum;
        pe_idx_t exp_idx;
        if (i_dot_engine_top.i_dot_engine_checker.error_count != 0)
        begin
            fail_run("a protocol assertion of the bound checker failed");
        end
        else if (rst_n && out_valid && out_ready)
        begin
            if (expected.size() == 0)
            begin
                fail_run("an output beat arrived with no result outstanding");
            end
            else
            begin
                exp_sum = expected.pop_front();
                exp_idx = pe_idx_t'(out_count % N_PE);
                out_count++;
                assert (out_sum == exp_sum && out_index == exp_idx)
                else fail_run($sformatf("FAILED %s: expected sum %0d index %0d, actual sum %0d index %0d",
                    test_name, exp_sum, exp_idx, out_sum, out_index));
            end
        end
    end

    initial
    begin
        #(WATCHDOG_NS);
        fail_run("watchdog expired before all results arrived");
    end

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial
    begin
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_act    = '0;
        in_weight = '0;
        in_last   = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // First tile also exercises the 4-cycle latency check
        test_name = "after_reset";
        assert (!out_valid && in_ready)
        else fail_run("after reset out_valid is high or in_ready is low");
        send_tile(1, 0);
        wait_drain();

        test_name = "single_beat";
        repeat (8) send_tile(1, 0);
        wait_drain();

        // 160 beats push both corners past the 21-bit range
        test_name = "extreme_wrap";
        send_tile(40, 1);
        send_tile(40, 2);
        send_tile(160, 1);
        send_tile(160, 2);
        wait_drain();

        test_name = "back_to_back";
        repeat (8) send_tile(1 + next_rand() % 3, 0);
        wait_drain();

        test_name = "stalled_output";
        ready_level <= 1'b0;
        for (int t = 0; t < TILE_FIFO_DEPTH; t++)
        begin
            send_tile(1, 0);
            assert (in_ready == (t < TILE_FIFO_DEPTH - 1))
            else fail_run($sformatf("in_ready wrong after %0d stalled tiles", t + 1));
        end
        repeat (6) @(posedge clk);
        #1;
        assert (!in_ready)
        else fail_run("in_ready rose while all tile slots were still held");
        ready_level <= 1'b1;
        wait_drain();

        test_name = "random_ready";
        ready_random <= 1'b1;
        repeat (12) send_tile(1 + next_rand() % 4, 0);
        wait_drain();
        ready_random <= 1'b0;
        repeat (4) @(posedge clk);

        if (expected.size() == 0 && out_count == N_TILES * N_PE)
        begin
            $display("test passed");
            $finish;
        end
        else
        begin
            fail_run($sformatf("%0d output beats seen, %0d expected", out_count, N_TILES * N_PE));
        end
    end

endmodule
